// ==== src/vram_pkg.sv ====
/* memory-wide types shared by arbiter, banks and mux
   address covers all banks together, bank index sits in the top bits */

`default_nettype none

package vram_pkg;

    // word address across the whole memory
    localparam int VRAM_ADDR_W = 12;

    // one memory word
    localparam int VRAM_DATA_W = 16;

    typedef logic [VRAM_ADDR_W-1:0] addr_t;   // full word address
    typedef logic [VRAM_DATA_W-1:0] word_t;   // memory word

    // power-up content of every bank, easy to spot in a waveform
    localparam word_t FILL_WORD = 16'hdead;

endpackage

`default_nettype wire

// ==== src/vram_bus_pkg.sv ====
/* requester tags carried with each request so read data finds its way back
   only two requesters, so the tag is a single bit */

`default_nettype none

package vram_bus_pkg;

    // names the requester that issued a memory access
    typedef logic [0:0] tag_t;

    localparam tag_t TAG_HOST  = 1'b0;   // host bus port
    localparam tag_t TAG_VIDEO = 1'b1;   // display fetch port

endpackage

`default_nettype wire

// ==== src/vram_req_if.sv ====
/* registered request from the arbiter, seen by every bank and the read mux
   BANK_AW must equal VRAM_ADDR_W minus log2 of the bank count */

`default_nettype none

interface vram_req_if #(
    parameter int BANK_AW = 10
);

    localparam int BANK_W = vram_pkg::VRAM_ADDR_W - BANK_AW;

    logic                 req_valid;   // request present this cycle
    logic                 req_wr;      // write, else read
    logic [BANK_W-1:0]    req_bank;    // target bank index
    logic [BANK_AW-1:0]   req_addr;    // word address inside the bank
    vram_pkg::word_t      req_wdata;
    vram_bus_pkg::tag_t   req_tag;     // who asked

    modport arb (
        output req_valid, req_wr, req_bank, req_addr, req_wdata, req_tag
    );

    // each bank matches req_bank against its own index
    modport bank (
        input req_valid, req_wr, req_bank, req_addr, req_wdata
    );

    modport mux (
        input req_valid, req_wr, req_bank, req_tag
    );

endinterface

`default_nettype wire

// ==== src/vram_arbiter.sv ====
/* fixed priority, video always wins; host_ready is combinational from vid_valid
   host must hold its request stable until accepted */

`default_nettype none

module vram_arbiter #(
    parameter int NUM_BANKS = 4,
    parameter int BANK_AW   = 10
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              host_valid,
    input  logic              host_wr,
    input  vram_pkg::addr_t   host_addr,
    input  vram_pkg::word_t   host_wdata,
    output logic              host_ready,
    input  logic              vid_valid,
    input  vram_pkg::addr_t   vid_addr,
    vram_req_if.arb           req
);

    localparam int BANK_W = $clog2(NUM_BANKS);

    logic              host_accept;   // host transfer this cycle
    logic              accept;        // any request taken this cycle
    vram_pkg::addr_t   pick_addr;

    // video is never stalled, host only gets the free cycles
    assign host_ready  = ~vid_valid;
    assign host_accept = host_valid & host_ready;
    assign accept      = vid_valid | host_accept;

    assign pick_addr = vid_valid ? vid_addr : host_addr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req.req_valid <= 1'b0;
        end else begin
            req.req_valid <= accept;   // drops in idle cycles
        end
    end

    // payload, only meaningful while req_valid is high
    always_ff @(posedge clk) begin
        if (accept) begin
            req.req_bank  <= pick_addr[vram_pkg::VRAM_ADDR_W-1 -: BANK_W];
            req.req_addr  <= pick_addr[BANK_AW-1:0];
            req.req_wdata <= host_wdata;
            if (vid_valid) begin
                req.req_wr  <= 1'b0;   // video port is read only
                req.req_tag <= vram_bus_pkg::TAG_VIDEO;
            end else begin
                req.req_wr  <= host_wr;
                req.req_tag <= vram_bus_pkg::TAG_HOST;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/vram_bank.sv ====
/* one inferred synchronous single-port RAM, read-before-write on rdata
   content after power-up is FILL_WORD, there is no clear on reset */

`default_nettype none

module vram_bank #(
    parameter int BANK_INDEX = 0,
    parameter int BANK_AW    = 10
) (
    input  logic              clk,
    vram_req_if.bank          req,
    output vram_pkg::word_t   rdata
);

    localparam int BANK_W = vram_pkg::VRAM_ADDR_W - BANK_AW;
    localparam int DEPTH  = 1 << BANK_AW;
    localparam logic [BANK_W-1:0] BANK_SEL = BANK_W'(BANK_INDEX);

    vram_pkg::word_t mem [DEPTH];
    logic            sel;

    // fill with garbage so unwritten words are recognizable
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = vram_pkg::FILL_WORD;
        end
    end

    assign sel = req.req_valid && (req.req_bank == BANK_SEL);

    always_ff @(posedge clk) begin
        if (sel) begin
            if (req.req_wr) begin
                mem[req.req_addr] <= req.req_wdata;
            end
            rdata <= mem[req.req_addr];   // old word on a write
        end
    end

endmodule

`default_nettype wire

// ==== src/vram_read_mux.sv ====
/* remembers bank and requester of each read, then steers that bank's word out
   both rdata outputs carry the same word, only the valid lines differ */

`default_nettype none

module vram_read_mux #(
    parameter int NUM_BANKS = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    vram_req_if.mux           req,
    input  vram_pkg::word_t   bank_rdata [NUM_BANKS],
    output logic              host_rd_valid,
    output logic              vid_rd_valid,
    output vram_pkg::word_t   host_rdata,
    output vram_pkg::word_t   vid_rdata
);

    localparam int BANK_W = $clog2(NUM_BANKS);

    logic                 rd_pend;   // bank read in flight
    logic [BANK_W-1:0]    rd_bank;
    vram_bus_pkg::tag_t   rd_tag;
    vram_pkg::word_t      rd_word;

    // captured on the same edge the bank reads
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pend <= 1'b0;
            rd_bank <= '0;
            rd_tag  <= vram_bus_pkg::TAG_HOST;
        end else begin
            rd_pend <= req.req_valid & ~req.req_wr;   // writes give no response
            if (req.req_valid) begin
                rd_bank <= req.req_bank;
                rd_tag  <= req.req_tag;
            end
        end
    end

    assign rd_word = bank_rdata[rd_bank];

    assign host_rd_valid = rd_pend && (rd_tag == vram_bus_pkg::TAG_HOST);
    assign vid_rd_valid  = rd_pend && (rd_tag == vram_bus_pkg::TAG_VIDEO);

    assign host_rdata = rd_word;
    assign vid_rdata  = rd_word;

endmodule

`default_nettype wire

// ==== src/vram_top.sv ====
/* banked video memory, NUM_BANKS must be a power of two from 2 to 8
   reads return 2 cycles after acceptance, writes are silent */

`default_nettype none

module vram_top #(
    parameter int NUM_BANKS = 4
) (
    input  logic              clk,
    input  logic              rst_n,

    // host bus, read and write
    input  logic              host_valid,
    output logic              host_ready,
    input  logic              host_wr,
    input  vram_pkg::addr_t   host_addr,
    input  vram_pkg::word_t   host_wdata,
    output logic              host_rd_valid,
    output vram_pkg::word_t   host_rdata,

    // display fetch, read only and never stalled
    input  logic              vid_valid,
    input  vram_pkg::addr_t   vid_addr,
    output logic              vid_rd_valid,
    output vram_pkg::word_t   vid_rdata
);

    // in-bank address width, top bits pick the bank
    localparam int BANK_AW = vram_pkg::VRAM_ADDR_W - $clog2(NUM_BANKS);

    vram_pkg::word_t bank_rdata [NUM_BANKS];

    vram_req_if #(
        .BANK_AW (BANK_AW)
    ) req_if ();

    vram_arbiter #(
        .NUM_BANKS (NUM_BANKS),
        .BANK_AW   (BANK_AW)
    ) u_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .host_valid (host_valid),
        .host_wr    (host_wr),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_ready (host_ready),
        .vid_valid  (vid_valid),
        .vid_addr   (vid_addr),
        .req        (req_if)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        vram_bank #(
            .BANK_INDEX (b),
            .BANK_AW    (BANK_AW)
        ) u_bank (
            .clk   (clk),
            .req   (req_if),
            .rdata (bank_rdata[b])
        );
    end

    vram_read_mux #(
        .NUM_BANKS (NUM_BANKS)
    ) u_read_mux (
        .clk           (clk),
        .rst_n         (rst_n),
        .req           (req_if),
        .bank_rdata    (bank_rdata),
        .host_rd_valid (host_rd_valid),
        .vid_rd_valid  (vid_rd_valid),
        .host_rdata    (host_rdata),
        .vid_rdata     (vid_rdata)
    );

endmodule

`default_nettype wire

// ==== test/vram_chk.sv ====
/* protocol checks on the top-level ports, bound into every vram_top
   latency checks assume no reset while a read is in flight */

`default_nettype none

module vram_chk (
    input logic clk,
    input logic rst_n,
    input logic host_valid,
    input logic host_ready,
    input logic host_wr,
    input logic host_rd_valid,
    input logic vid_valid,
    input logic vid_rd_valid
);

    timeunit 1ns;
    timeprecision 100ps;

    // accepted host read answers two edges later
    host_read_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (host_valid && host_ready && !host_wr) |-> ##2 host_rd_valid)
        else $error("host read did not return after 2 cycles");

    vid_read_latency: assert property (@(posedge clk) disable iff (!rst_n)
        vid_valid |-> ##2 vid_rd_valid)
        else $error("video read did not return after 2 cycles");

    // video always wins the port
    ready_vs_video: assert property (@(posedge clk) disable iff (!rst_n)
        !(host_ready && vid_valid))
        else $error("host_ready high while video is active");

    quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> (!host_rd_valid && !vid_rd_valid))
        else $error("read valid high during reset");

endmodule

bind vram_top vram_chk u_chk (
    .clk           (clk),
    .rst_n         (rst_n),
    .host_valid    (host_valid),
    .host_ready    (host_ready),
    .host_wr       (host_wr),
    .host_rd_valid (host_rd_valid),
    .vid_valid     (vid_valid),
    .vid_rd_valid  (vid_rd_valid)
);

`default_nettype wire

// ==== test/vram_tb.sv ====
/* directed tests for vram_top with 4 banks, a reference model and a cycle monitor
   the monitor expects every accepted read back exactly 2 cycles later */

`default_nettype none

module vram_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 4;
    localparam int N_BANKS      = 4;
    localparam int BANK_DEPTH   = (1 << vram_pkg::VRAM_ADDR_W) / N_BANKS;
    localparam int MEM_WORDS    = 1 << vram_pkg::VRAM_ADDR_W;
    localparam int N_RAND       = 16;
    localparam int DRAIN_CYCLES = 4;
    localparam int ACCEPT_LIMIT = 16;
    localparam int RUN_CYCLES   = RESET_CYCLES + 6 * DRAIN_CYCLES + 2 * N_BANKS
                                  + 4 * N_RAND + 12 + 2 * N_BANKS;
    localparam int WATCHDOG_NS  = 2 * RUN_CYCLES * CLK_PERIOD;   // double for margin
    localparam logic [31:0] SEED = 32'h68d7_823d;

    logic clk;
    logic rst_n;
    logic host_valid, host_ready, host_wr, host_rd_valid;
    logic vid_valid, vid_rd_valid;
    vram_pkg::addr_t host_addr, vid_addr;
    vram_pkg::word_t host_wdata, host_rdata, vid_rdata;

    vram_pkg::word_t model [MEM_WORDS];   // expected memory content
    vram_pkg::addr_t wr_addr [N_RAND];    // addresses written in the readback test

    // index 1 holds the response due at this negedge
    logic            p_host [2] = '{1'b0, 1'b0};
    logic            p_vid  [2] = '{1'b0, 1'b0};
    vram_pkg::word_t p_data [2];

    vram_top #(
        .NUM_BANKS (N_BANKS)
    ) u_vram_top (
        .clk (clk), .rst_n (rst_n),
        .host_valid (host_valid), .host_ready (host_ready), .host_wr (host_wr),
        .host_addr (host_addr), .host_wdata (host_wdata),
        .host_rd_valid (host_rd_valid), .host_rdata (host_rdata),
        .vid_valid (vid_valid), .vid_addr (vid_addr),
        .vid_rd_valid (vid_rd_valid), .vid_rdata (vid_rdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic compare_bit(string name, logic got, logic exp);
        assert (got === exp) else abort_run($sformatf(
            "MISMATCH time %0t %s got %b expected %b", $time, name, got, exp));
    endtask

    task automatic compare_word(string name, vram_pkg::word_t got, vram_pkg::word_t exp);
        assert (got === exp) else abort_run($sformatf(
            "MISMATCH time %0t %s got %h expected %h", $time, name, got, exp));
    endtask

    // mid-cycle monitor sees stable inputs and outputs
    always @(negedge clk) begin
        if (rst_n) begin
            compare_bit("host_rd_valid", host_rd_valid, p_host[1]);
            compare_bit("vid_rd_valid", vid_rd_valid, p_vid[1]);
            if (p_host[1]) compare_word("host_rdata", host_rdata, p_data[1]);
            if (p_vid[1])  compare_word("vid_rdata", vid_rdata, p_data[1]);
            p_host[1] = p_host[0];
            p_vid[1]  = p_vid[0];
            p_data[1] = p_data[0];
            p_vid[0]  = vid_valid;   // video wins the cycle
            p_host[0] = !vid_valid && host_valid && !host_wr;
            p_data[0] = model[vid_valid ? vid_addr : host_addr];
            if (!vid_valid && host_valid && host_wr) model[host_addr] = host_wdata;
        end
    end

    task automatic step();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    function automatic vram_pkg::addr_t make_addr(int bank, int offset);
        return vram_pkg::addr_t'(bank * BANK_DEPTH + offset % BANK_DEPTH);
    endfunction

    task automatic drain_pipeline();
        host_valid = 1'b0;
        vid_valid  = 1'b0;
        repeat (DRAIN_CYCLES) step();
    endtask

    task automatic wait_host_accept();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!host_ready) begin
            waited++;
            assert (waited < ACCEPT_LIMIT) else abort_run("host request was never accepted");
            @(negedge clk);
        end
        step();
    endtask

    // leaves host_valid high so the next access follows without a gap
    task automatic host_access(logic wr, vram_pkg::addr_t addr, vram_pkg::word_t data);
        host_valid = 1'b1;
        host_wr    = wr;
        host_addr  = addr;
        host_wdata = data;
        wait_host_accept();
    endtask

    task automatic check_reset_state();
        @(negedge clk);
        compare_bit("host_rd_valid", host_rd_valid, 1'b0);
        compare_bit("vid_rd_valid", vid_rd_valid, 1'b0);
        compare_bit("host_ready", host_ready, 1'b1);
        step();
    endtask

    task automatic read_unwritten();
        for (int b = 0; b < N_BANKS; b++) begin
            host_access(1'b0, make_addr(b, $urandom_range(BANK_DEPTH - 1)), '0);
        end
        drain_pipeline();
    endtask

    task automatic write_read_back();
        for (int i = 0; i < N_RAND; i++) begin
            wr_addr[i] = make_addr(i % N_BANKS, $urandom_range(BANK_DEPTH - 1));
            host_access(1'b1, wr_addr[i], vram_pkg::word_t'($urandom));
        end
        for (int i = 0; i < N_RAND; i++) host_access(1'b0, wr_addr[i], '0);
        drain_pipeline();
    endtask

    task automatic video_priority();
        host_valid = 1'b1;   // host read left pending behind video
        host_wr    = 1'b0;
        host_addr  = wr_addr[N_RAND - 1];
        for (int i = 0; i < 6; i++) begin
            vid_valid = 1'b1;
            vid_addr  = wr_addr[i];
            @(negedge clk);
            assert (!host_ready) else abort_run("host_ready was high during video reads");
            step();
        end
        vid_valid = 1'b0;
        wait_host_accept();
        drain_pipeline();
    endtask

    task automatic mixed_pipeline();
        for (int i = 0; i < N_RAND; i++) begin
            host_valid = (i % 2 == 0);
            vid_valid  = (i % 2 == 1);
            host_wr    = 1'b0;
            host_addr  = wr_addr[i];
            vid_addr   = wr_addr[i];
            step();
        end
        drain_pipeline();
    endtask

    task automatic write_then_read();
        vram_pkg::addr_t a;
        for (int b = 0; b < N_BANKS; b++) begin
            a = wr_addr[b];
            host_access(1'b1, a, vram_pkg::word_t'($urandom));
            host_access(1'b0, a, '0);   // same word in the very next cycle
        end
        drain_pipeline();
    endtask

    initial begin
        #WATCHDOG_NS;
        abort_run("watchdog expired before the tests finished");
    end

    initial begin
        void'($urandom(SEED));
        clk        = 1'b0;
        rst_n      = 1'b0;
        host_valid = 1'b0;
        host_wr    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        vid_valid  = 1'b0;
        vid_addr   = '0;
        for (int i = 0; i < MEM_WORDS; i++) model[i] = vram_pkg::FILL_WORD;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY rst_n = 1'b1;
        check_reset_state();
        read_unwritten();
        write_read_back();
        video_priority();
        mixed_pipeline();
        write_then_read();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
src/vram_pkg.sv
src/vram_bus_pkg.sv
src/vram_req_if.sv
src/vram_arbiter.sv
src/vram_bank.sv
src/vram_read_mux.sv
src/vram_top.sv
test/vram_chk.sv
test/vram_tb.sv
